// ==== dead_time_generator.sv ====
`timescale 1ns/1ns

module dead_time_generator #(
    parameter int unsigned COUNTER_WIDTH = pwm_pkg::COUNTER_WIDTH
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     enable,
    input  logic [COUNTER_WIDTH-1:0] dead_time,
    input  logic                     raw_a,
    input  logic                     raw_b,
    output logic                     gate_a_next,
    output logic                     gate_b_next
);

    import pwm_pkg::*;

    dt_state_t                state;
    logic [COUNTER_WIDTH-1:0] counter;
    logic [COUNTER_WIDTH-1:0] load_value;
    logic                     counter_done;

    // Loading dead_time-1 gives exactly dead_time cycles in a dead state
    assign load_value   = dead_time - 1'b1;
    assign counter_done = (counter == '0);

    always_ff @(posedge clock) begin
        if (!reset) begin
            state   <= idle;
            counter <= '0;
        end else if (!enable) begin
            // Bypassed, the sequencer keeps its state and the counter stays loaded
            counter <= load_value;
        end else begin
            case (state)
                idle: begin
                    counter <= load_value;
                    if (raw_a) begin
                        state <= first_dead;
                    end
                end
                first_dead: begin
                    if (counter_done) begin
                        counter <= load_value;
                        state   <= a_on;
                    end else begin
                        counter <= counter - 1'b1;
                    end
                end
                a_on: begin
                    counter <= load_value;
                    if (raw_b) begin
                        state <= second_dead;
                    end
                end
                second_dead: begin
                    if (counter_done) begin
                        counter <= load_value;
                        state   <= idle;
                    end else begin
                        counter <= counter - 1'b1;
                    end
                end
                default: begin
                    counter <= load_value;
                    state   <= idle;
                end
            endcase
        end
    end

    // Gate levels come straight from the state, or from the carrier when bypassed
    always_comb begin
        if (!enable) begin
            gate_a_next = raw_a;
            gate_b_next = raw_b;
        end else begin
            case (state)
                idle: begin
                    gate_a_next = 1'b0;
                    gate_b_next = 1'b1;
                end
                a_on: begin
                    gate_a_next = 1'b1;
                    gate_b_next = 1'b0;
                end
                first_dead, second_dead: begin
                    gate_a_next = 1'b0;
                    gate_b_next = 1'b0;
                end
                default: begin
                    gate_a_next = 1'b0;
                    gate_b_next = 1'b1;
                end
            endcase
        end
    end

endmodule

// ==== gate_output_stage.sv ====
`timescale 1ns/1ns

module gate_output_stage (
    input  logic clock,
    input  logic reset,
    input  logic gate_a_next,
    input  logic gate_b_next,
    input  logic fault,
    input  logic fault_clear,
    output logic gate_a,
    output logic gate_b,
    output logic fault_latched
);

    logic gates_blocked;

    assign gates_blocked = fault || fault_latched;

    // A live fault wins over a clear request on the same cycle
    always_ff @(posedge clock) begin
        if (!reset) begin
            fault_latched <= 1'b0;
        end else if (fault) begin
            fault_latched <= 1'b1;
        end else if (fault_clear) begin
            fault_latched <= 1'b0;
        end
    end

    // Both switches off during a fault so the bridge can never shoot through
    always_ff @(posedge clock) begin
        if (!reset) begin
            gate_a <= 1'b0;
            gate_b <= 1'b0;
        end else if (gates_blocked) begin
            gate_a <= 1'b0;
            gate_b <= 1'b0;
        end else begin
            gate_a <= gate_a_next;
            gate_b <= gate_b_next;
        end
    end

endmodule

// ==== pwm_carrier.sv ====
`timescale 1ns/1ns

module pwm_carrier #(
    parameter int unsigned COUNTER_WIDTH = pwm_pkg::COUNTER_WIDTH
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [COUNTER_WIDTH-1:0] period,
    input  logic [COUNTER_WIDTH-1:0] compare,
    output logic                     raw_a,
    output logic                     raw_b
);

    logic [COUNTER_WIDTH-1:0] count;
    logic [COUNTER_WIDTH-1:0] last_count;
    logic                     level_a;

    assign last_count = period - 1'b1;
    assign level_a    = (count < compare);

    // Sawtooth from 0 to period-1 that stops at zero while no period is set
    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
        end else if (period == '0) begin
            count <= '0;
        end else if (count >= last_count) begin
            // Also catches a count left above a newly shortened period
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            raw_a <= 1'b0;
            raw_b <= 1'b1;
        end else if (period == '0) begin
            raw_a <= 1'b0;
            raw_b <= 1'b1;
        end else begin
            raw_a <= level_a;
            raw_b <= !level_a;
        end
    end

endmodule

// ==== pwm_config_regs.sv ====
`timescale 1ns/1ns

module pwm_config_regs #(
    parameter int unsigned COUNTER_WIDTH = pwm_pkg::COUNTER_WIDTH
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     wr_strobe,
    input  logic                     wr_addr,
    input  pwm_pkg::cfg_word_t       wr_data,
    output logic [COUNTER_WIDTH-1:0] period,
    output logic [COUNTER_WIDTH-1:0] compare,
    output logic [COUNTER_WIDTH-1:0] dead_time,
    output logic                     dt_enable,
    output logic                     fault_clear
);

    import pwm_pkg::*;

    logic timing_write;
    logic control_write;

    assign timing_write  = wr_strobe && (wr_addr == CFG_ADDR_TIMING);
    assign control_write = wr_strobe && (wr_addr == CFG_ADDR_CONTROL);

    // Stored fields are taken from the view that matches the address
    always_ff @(posedge clock) begin
        if (!reset) begin
            period    <= '0;
            compare   <= '0;
            dead_time <= '0;
            dt_enable <= 1'b0;
        end else begin
            if (timing_write) begin
                period  <= COUNTER_WIDTH'(wr_data.timing.period);
                compare <= COUNTER_WIDTH'(wr_data.timing.compare);
            end
            if (control_write) begin
                dead_time <= COUNTER_WIDTH'(wr_data.control.dead_time);
                dt_enable <= wr_data.control.flags[FLAG_ENABLE_BIT];
            end
        end
    end

    // Fault clear is a command, so it only lives for one cycle
    always_ff @(posedge clock) begin
        if (!reset) begin
            fault_clear <= 1'b0;
        end else begin
            fault_clear <= control_write && wr_data.control.flags[FLAG_FAULT_CLEAR_BIT];
        end
    end

endmodule

// ==== pwm_deadtime_top.sv ====
`timescale 1ns/1ns

module pwm_deadtime_top #(
    parameter int unsigned COUNTER_WIDTH = pwm_pkg::COUNTER_WIDTH
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               wr_strobe,
    input  logic               wr_addr,
    input  pwm_pkg::cfg_word_t wr_data,
    input  logic               fault,
    output logic               gate_a,
    output logic               gate_b,
    output logic               fault_latched
);

    logic [COUNTER_WIDTH-1:0] period;
    logic [COUNTER_WIDTH-1:0] compare;
    logic [COUNTER_WIDTH-1:0] dead_time;
    logic                     dt_enable;
    logic                     fault_clear;
    logic                     raw_a;
    logic                     raw_b;
    logic                     gate_a_next;
    logic                     gate_b_next;

    pwm_config_regs #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) pwm_config_regs_i (
        .clock      (clock),
        .reset      (reset),
        .wr_strobe  (wr_strobe),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .period     (period),
        .compare    (compare),
        .dead_time  (dead_time),
        .dt_enable  (dt_enable),
        .fault_clear(fault_clear)
    );

    pwm_carrier #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) pwm_carrier_i (
        .clock  (clock),
        .reset  (reset),
        .period (period),
        .compare(compare),
        .raw_a  (raw_a),
        .raw_b  (raw_b)
    );

    dead_time_generator #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) dead_time_generator_i (
        .clock      (clock),
        .reset      (reset),
        .enable     (dt_enable),
        .dead_time  (dead_time),
        .raw_a      (raw_a),
        .raw_b      (raw_b),
        .gate_a_next(gate_a_next),
        .gate_b_next(gate_b_next)
    );

    gate_output_stage gate_output_stage_i (
        .clock        (clock),
        .reset        (reset),
        .gate_a_next  (gate_a_next),
        .gate_b_next  (gate_b_next),
        .fault        (fault),
        .fault_clear  (fault_clear),
        .gate_a       (gate_a),
        .gate_b       (gate_b),
        .fault_latched(fault_latched)
    );

endmodule

// ==== pwm_patterns.txt ====
# id period compare dead_time enable fault_mode exp_a_width exp_b_width exp_gap_width
# Decimal fields; a zero period is observed over a 16-cycle window
1 20 10 2 1 0 8 8 2
2 32 12 3 1 0 9 17 3
3 16 5 1 1 0 4 10 1
4 24 9 0 0 0 9 15 0
5 40 20 4 1 1 16 16 4
6 0 0 3 1 0 0 16 0
7 48 30 5 1 0 25 13 5
8 20 8 3 1 1 5 9 3
9 10 3 1 1 0 2 6 1
10 12 6 2 0 0 6 6 0

// ==== pwm_pkg.sv ====
package pwm_pkg;

    // Width of the period, compare and dead-time counters
    localparam int unsigned COUNTER_WIDTH = 16;

    // Each register word carries two fields of this width
    localparam int unsigned CFG_FIELD_WIDTH = 16;

    // Register map with a single address bit
    localparam logic CFG_ADDR_TIMING  = 1'b0;
    localparam logic CFG_ADDR_CONTROL = 1'b1;

    // Bit positions inside the control flags field
    localparam int unsigned FLAG_ENABLE_BIT      = 0;
    localparam int unsigned FLAG_FAULT_CLEAR_BIT = 1;

    typedef struct packed {
        logic [CFG_FIELD_WIDTH-1:0] period;
        logic [CFG_FIELD_WIDTH-1:0] compare;
    } cfg_timing_t;

    typedef struct packed {
        logic [CFG_FIELD_WIDTH-1:0] dead_time;
        logic [CFG_FIELD_WIDTH-1:0] flags;
    } cfg_control_t;

    // The same 32-bit write word is read as timing or control by address
    typedef union packed {
        cfg_timing_t  timing;
        cfg_control_t control;
    } cfg_word_t;

    // Dead-time sequencer states
    typedef enum logic [1:0] {
        idle        = 2'd0,
        first_dead  = 2'd1,
        a_on        = 2'd2,
        second_dead = 2'd3
    } dt_state_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the PWM dead-time testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_pwm_deadtime -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build did not complete"
    exit 1
fi

./obj_dir/Vtb_pwm_deadtime 2>&1 | tee sim.log
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "Simulation exited with an error status"
    exit 1
fi

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0

// ==== sim.f ====
pwm_pkg.sv
pwm_config_regs.sv
pwm_carrier.sv
dead_time_generator.sv
gate_output_stage.sv
pwm_deadtime_top.sv
tb_pwm_deadtime.sv

// ==== tb_pwm_deadtime.sv ====
`timescale 1ns/1ns

module tb_pwm_deadtime;

    import pwm_pkg::*;

    localparam int CLOCK_HALF   = 4;
    localparam int RESET_CYCLES = 3;
    localparam int MAX_TESTS    = 32;
    // With the carrier stopped there is no period, so a fixed window is observed
    localparam int IDLE_WINDOW  = 16;

    logic      clock;
    logic      reset;
    logic      wr_strobe;
    logic      wr_addr;
    cfg_word_t wr_data;
    logic      fault;
    logic      gate_a;
    logic      gate_b;
    logic      fault_latched;

    int pat_id      [MAX_TESTS];
    int pat_period  [MAX_TESTS];
    int pat_compare [MAX_TESTS];
    int pat_dead    [MAX_TESTS];
    int pat_enable  [MAX_TESTS];
    int pat_fault   [MAX_TESTS];
    int exp_a       [MAX_TESTS];
    int exp_b       [MAX_TESTS];
    int exp_gap     [MAX_TESTS];

    int test_count;
    int error_count;
    int passed_count;
    int failed_count;
    int cycle_count;
    int timeout_limit;
    bit limit_ready;
    bit monitor_on;

    pwm_deadtime_top #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) pwm_deadtime_top_i (
        .clock        (clock),
        .reset        (reset),
        .wr_strobe    (wr_strobe),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .fault        (fault),
        .gate_a       (gate_a),
        .gate_b       (gate_b),
        .fault_latched(fault_latched)
    );

    initial begin
        clock = 1'b0;
        forever #CLOCK_HALF clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input string name, input int got, input int expected);
        if (got !== expected) begin
            $display("[FAIL] %0t ns: %s got %0d, expected %0d", $time, name, got, expected);
            error_count++;
        end
    endtask

    // The shoot-through guard looks at every cycle once reset is released
    always @(negedge clock) begin
        if (monitor_on) begin
            check_value("gate_a and gate_b together", int'(gate_a && gate_b), 0);
        end
    end

    initial begin : watchdog
        wait (limit_ready);
        while (cycle_count <= timeout_limit) begin
            @(posedge clock);
        end
        $display("Timeout: the run went past %0d clock cycles without finishing", timeout_limit);
        $display("Testbench failed");
        $finish;
    end

    task automatic load_patterns(input int fd);
        string line;
        int    fields;
        while (!$feof(fd) && test_count < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            // Lines starting with # describe the columns
            if (line.len() > 0 && line.substr(0, 0) != "#") begin
                fields = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                                 pat_id[test_count], pat_period[test_count],
                                 pat_compare[test_count], pat_dead[test_count],
                                 pat_enable[test_count], pat_fault[test_count],
                                 exp_a[test_count], exp_b[test_count], exp_gap[test_count]);
                if (fields == 9) begin
                    test_count++;
                end
            end
        end
    endtask

    task automatic drive_write(input logic addr, input cfg_word_t data);
        wr_strobe = 1'b1;
        wr_addr   = addr;
        wr_data   = data;
        @(negedge clock);
        wr_strobe = 1'b0;
    endtask

    function automatic cfg_word_t control_word(input int dead, input int enable, input bit clear);
        cfg_word_t word;
        word = '0;
        word.control.dead_time                   = CFG_FIELD_WIDTH'(dead);
        word.control.flags[FLAG_ENABLE_BIT]      = (enable != 0);
        word.control.flags[FLAG_FAULT_CLEAR_BIT] = clear;
        return word;
    endfunction

    // Stops on the first cycle of a gate_a pulse that follows a gate_b phase
    task automatic align_to_gate_a(input int limit, output bit found);
        int cycles;
        cycles = 0;
        while (gate_b !== 1'b1 && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        while (gate_a !== 1'b1 && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        found = (gate_a === 1'b1);
    endtask

    task automatic measure_window(input int window, output int a_count, output int b_count,
                                  output int gap_min, output int gap_max);
        int run;
        bit any_gap;
        a_count = 0;
        b_count = 0;
        gap_min = 0;
        gap_max = 0;
        run     = 0;
        any_gap = 1'b0;
        for (int i = 0; i < window; i++) begin
            if (gate_a === 1'b1) a_count++;
            if (gate_b === 1'b1) b_count++;
            if (gate_a === 1'b0 && gate_b === 1'b0) begin
                run++;
            end else if (run > 0) begin
                if (!any_gap || run < gap_min) gap_min = run;
                if (run > gap_max) gap_max = run;
                any_gap = 1'b1;
                run     = 0;
            end
            @(negedge clock);
        end
        // The second gap ends right at the window edge
        if (run > 0) begin
            if (!any_gap || run < gap_min) gap_min = run;
            if (run > gap_max) gap_max = run;
        end
    endtask

    task automatic apply_fault(input int idx);
        repeat (pat_period[idx] / 2) @(negedge clock);
        fault = 1'b1;
        @(negedge clock);
        fault = 1'b0;
        for (int i = 0; i < pat_period[idx]; i++) begin
            check_value("fault_latched while held", int'(fault_latched), 1);
            check_value("gate_a during fault", int'(gate_a), 0);
            check_value("gate_b during fault", int'(gate_b), 0);
            @(negedge clock);
        end
        drive_write(CFG_ADDR_CONTROL, control_word(pat_dead[idx], pat_enable[idx], 1'b1));
        @(negedge clock);
        check_value("fault_latched after clear", int'(fault_latched), 0);
    endtask

    task automatic run_test(input int idx);
        cfg_word_t word;
        int        errors_before;
        int        window;
        int        a_count;
        int        b_count;
        int        gap_min;
        int        gap_max;
        bit        found;
        dt_state_t seen_state;
        errors_before       = error_count;
        word                = '0;
        word.timing.period  = CFG_FIELD_WIDTH'(pat_period[idx]);
        word.timing.compare = CFG_FIELD_WIDTH'(pat_compare[idx]);
        drive_write(CFG_ADDR_TIMING, word);
        drive_write(CFG_ADDR_CONTROL, control_word(pat_dead[idx], pat_enable[idx], 1'b0));
        // Two carrier periods, plus room for the sequencer to leave a stale dead state
        repeat (2 * pat_period[idx] + 2 * pat_dead[idx] + 6) @(negedge clock);
        if (pat_fault[idx] != 0) begin
            apply_fault(idx);
        end
        found  = 1'b1;
        window = IDLE_WINDOW;
        if (pat_period[idx] != 0) begin
            window = pat_period[idx];
            align_to_gate_a(3 * pat_period[idx] + 2 * pat_dead[idx] + 8, found);
        end
        if (!found) begin
            $display("Test %0d: gate_a never rose, so no period could be measured", pat_id[idx]);
            error_count++;
        end else begin
            measure_window(window, a_count, b_count, gap_min, gap_max);
            check_value("gate_a high width", a_count, exp_a[idx]);
            check_value("gate_b high width", b_count, exp_b[idx]);
            check_value("shortest gap", gap_min, exp_gap[idx]);
            check_value("longest gap", gap_max, exp_gap[idx]);
        end
        if (error_count == errors_before) begin
            passed_count++;
            $display("Test %0d ok: a %0d, b %0d, gap %0d", pat_id[idx], a_count, b_count, gap_max);
        end else begin
            failed_count++;
            seen_state = pwm_deadtime_top_i.dead_time_generator_i.state;
            $display("Test %0d has %0d mismatches, sequencer in %s", pat_id[idx],
                     error_count - errors_before, seen_state.name());
        end
    endtask

    initial begin : main
        int fd;
        reset         = 1'b0;
        wr_strobe     = 1'b0;
        wr_addr       = 1'b0;
        wr_data       = '0;
        fault         = 1'b0;
        test_count    = 0;
        error_count   = 0;
        passed_count  = 0;
        failed_count  = 0;
        cycle_count   = 0;
        timeout_limit = 0;
        limit_ready   = 1'b0;
        monitor_on    = 1'b0;
        fd = $fopen("pwm_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open pwm_patterns.txt for reading");
            $display("Testbench failed");
            $finish;
        end else begin
            load_patterns(fd);
            $fclose(fd);
            if (test_count == 0) begin
                $display("No test lines were found in pwm_patterns.txt");
                error_count++;
            end
            timeout_limit = RESET_CYCLES;
            for (int i = 0; i < test_count; i++) begin
                timeout_limit += 5 * pat_period[i] + 20;
            end
            limit_ready = 1'b1;
            repeat (RESET_CYCLES) @(negedge clock);
            reset      = 1'b1;
            monitor_on = 1'b1;
            for (int i = 0; i < test_count; i++) begin
                run_test(i);
            end
            $display("Tests run %0d, ok %0d, with mismatches %0d, total mismatches %0d",
                     test_count, passed_count, failed_count, error_count);
            if (error_count == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule
